/* Makefile */
VERILATOR ?= verilator
TOP       ?= ifetch_tb
RTL_TOP   ?= ifetch_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --Mdir $(BUILD_DIR) \
		--top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
logic/ifetch_pkg.sv
logic/fetch_pc_gen.sv
logic/icache_array.sv
logic/l2_refill_ctrl.sv
logic/ifetch_top.sv
test/ifetch_checker.sv
test/ifetch_tb.sv

/* logic/fetch_pc_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_pc_gen import ifetch_pkg::*;
#(
    parameter logic [addr_width-1:0] RESET_PC = '0
)
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  redirect_valid,
    input  wire logic [addr_width-1:0] redirect_pc,
    input  wire logic                  hit,
    output logic [addr_width-1:0]      pc,
    output logic                       drop
);

    logic                  pend_valid;
    logic [addr_width-1:0] pend_pc;
    logic                  take;
    logic [addr_width-1:0] target;

    // Redirects move the PC only on a hit, so a refill in flight runs to the end
    assign take   = hit && (redirect_valid || pend_valid);

    // A fresh strobe overrides a latched one
    assign target = redirect_valid ? redirect_pc : pend_pc;

    // Kill the word looked up in the redirect cycle
    assign drop   = take;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (take)
            pc <= target;
        else if (hit)
            pc <= pc + addr_width'(4);
    end

    ////////////////////////////////////////////////////////////////////
    // Redirect held while the PC is frozen on a miss
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pend_valid <= 1'b0;
        else if (take)
            pend_valid <= 1'b0;
        else if (redirect_valid)
            pend_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (redirect_valid && !take)
            pend_pc <= redirect_pc;
    end

endmodule

`default_nettype wire

/* logic/icache_array.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_array import ifetch_pkg::*;
#(
    parameter int WORD_PER_BLOCK = 16,
    parameter int LINE_COUNT     = 8
)
(
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic [addr_width-1:0]                pc,
    input  wire logic                                 drop,
    input  wire logic                                 fill_valid,
    input  wire l2_req_t                              fill_addr,
    input  wire logic [word_width*WORD_PER_BLOCK-1:0] fill_block,
    output logic                                      hit,
    output logic                                      miss,
    output l2_req_t                                   miss_block,
    output logic                                      fetch_valid,
    output fetch_out_t                                fetch
);

    localparam int block_width = word_width * WORD_PER_BLOCK;
    localparam int word_sel_w  = $clog2(WORD_PER_BLOCK);
    localparam int index_w     = $clog2(LINE_COUNT);
    localparam int tag_w       = block_addr_width - index_w;

    // Line storage
    logic [tag_w-1:0]       tag_mem  [LINE_COUNT];
    logic [block_width-1:0] data_mem [LINE_COUNT];
    logic [LINE_COUNT-1:0]  line_valid;

    // Lookup fields
    logic [block_addr_width-1:0] pc_block;
    logic [index_w-1:0]          pc_index;
    logic [tag_w-1:0]            pc_tag;
    logic [word_sel_w-1:0]       pc_word;
    logic [word_sel_w-1:0]       word_slot;
    logic [block_width-1:0]      line_data;

    // Fill fields
    logic [index_w-1:0]          fill_index;
    logic [tag_w-1:0]            fill_tag;

    ////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////

    assign pc_block  = pc[addr_width-1 -: block_addr_width];
    assign pc_index  = pc_block[index_w-1:0];
    assign pc_tag    = pc_block[block_addr_width-1:index_w];
    assign pc_word   = pc[word_sel_w+1:2];

    assign hit       = line_valid[pc_index] && (tag_mem[pc_index] == pc_tag);
    assign miss      = !hit;

    assign miss_block.block_addr = pc_block;

    // Word 0 sits in the top slot of the block, the way L2 packs it
    assign word_slot = word_sel_w'(WORD_PER_BLOCK - 1) - pc_word;
    assign line_data = data_mem[pc_index];

    ////////////////////////////////////////////////////////////////////
    // Fetch output, one cycle after the lookup
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            fetch_valid <= 1'b0;
        else
            fetch_valid <= hit && !drop;
    end

    always_ff @(posedge clk)
    begin
        if (hit)
        begin
            fetch.pc    <= pc;
            fetch.instr <= line_data[word_slot*word_width +: word_width];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Line fill
    ////////////////////////////////////////////////////////////////////

    assign fill_index = fill_addr.block_addr[index_w-1:0];
    assign fill_tag   = fill_addr.block_addr[block_addr_width-1:index_w];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            line_valid <= '0;
        else if (fill_valid)
            line_valid[fill_index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill_valid)
        begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_block;
        end
    end

    // PC stays frozen during a refill, so the fill lands on the block still missing
    assert property (@(posedge clk) disable iff (!rst_n)
        fill_valid |-> !hit && (fill_addr == miss_block))
        else $error("fill does not match the missing block");

endmodule

`default_nettype wire

/* logic/ifetch_pkg.sv */
`default_nettype none

package ifetch_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////

    // Byte address and instruction word
    localparam int addr_width       = 32;
    localparam int word_width       = 32;

    // 64-byte blocks, so the block address is the PC without its low 6 bits
    localparam int block_addr_width = 26;

    ////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////

    // Instruction handed to the core
    typedef struct packed {
        logic [addr_width-1:0] pc;
        logic [word_width-1:0] instr;
    } fetch_out_t;

    // Block request toward L2, also used for the line fill
    typedef struct packed {
        logic [block_addr_width-1:0] block_addr;
    } l2_req_t;

    // Refill sequence
    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_REQ,
        REFILL_WAIT,
        REFILL_FILL
    } refill_state_e;

endpackage

`default_nettype wire

/* logic/ifetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ifetch_top import ifetch_pkg::*;
#(
    parameter int                    WORD_PER_BLOCK = 16,
    parameter int                    LINE_COUNT     = 8,
    parameter logic [addr_width-1:0] RESET_PC       = '0
)
(
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    // Core side
    input  wire logic                                 redirect_valid,
    input  wire logic [addr_width-1:0]                redirect_pc,
    output logic                                      fetch_valid,
    output fetch_out_t                                fetch,
    // L2 side
    output logic                                      l2_addr_valid,
    output l2_req_t                                   l2_addr,
    input  wire logic                                 l2_addr_ready,
    input  wire logic                                 l2_data_valid,
    output logic                                      l2_data_ready,
    input  wire logic [word_width*WORD_PER_BLOCK-1:0] l2_data
);

    localparam int block_width = word_width * WORD_PER_BLOCK;

    logic [addr_width-1:0]  pc;
    logic                   drop;
    logic                   hit;
    logic                   miss;
    l2_req_t                miss_block;
    logic                   fill_valid;
    l2_req_t                fill_addr;
    logic [block_width-1:0] fill_block;

    fetch_pc_gen #(
        .RESET_PC       (RESET_PC)
    ) u_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hit            (hit),
        .pc             (pc),
        .drop           (drop)
    );

    icache_array #(
        .WORD_PER_BLOCK (WORD_PER_BLOCK),
        .LINE_COUNT     (LINE_COUNT)
    ) u_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc             (pc),
        .drop           (drop),
        .fill_valid     (fill_valid),
        .fill_addr      (fill_addr),
        .fill_block     (fill_block),
        .hit            (hit),
        .miss           (miss),
        .miss_block     (miss_block),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch)
    );

    l2_refill_ctrl #(
        .WORD_PER_BLOCK (WORD_PER_BLOCK)
    ) u_refill (
        .clk            (clk),
        .rst_n          (rst_n),
        .miss           (miss),
        .miss_block     (miss_block),
        .l2_addr_ready  (l2_addr_ready),
        .l2_data_valid  (l2_data_valid),
        .l2_data        (l2_data),
        .l2_addr_valid  (l2_addr_valid),
        .l2_addr        (l2_addr),
        .l2_data_ready  (l2_data_ready),
        .fill_valid     (fill_valid),
        .fill_addr      (fill_addr),
        .fill_block     (fill_block)
    );

endmodule

`default_nettype wire

/* logic/l2_refill_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module l2_refill_ctrl import ifetch_pkg::*;
#(
    parameter int WORD_PER_BLOCK = 16
)
(
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 miss,
    input  wire l2_req_t                              miss_block,
    input  wire logic                                 l2_addr_ready,
    input  wire logic                                 l2_data_valid,
    input  wire logic [word_width*WORD_PER_BLOCK-1:0] l2_data,
    output logic                                      l2_addr_valid,
    output l2_req_t                                   l2_addr,
    output logic                                      l2_data_ready,
    output logic                                      fill_valid,
    output l2_req_t                                   fill_addr,
    output logic [word_width*WORD_PER_BLOCK-1:0]      fill_block
);

    localparam int block_width = word_width * WORD_PER_BLOCK;

    refill_state_e          state;
    refill_state_e          state_next;
    l2_req_t                req_addr;
    logic [block_width-1:0] block_q;

    ////////////////////////////////////////////////////////////////////
    // Refill FSM
    ////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            REFILL_IDLE:
            begin
                if (miss)
                    state_next = REFILL_REQ;
            end
            REFILL_REQ:
            begin
                if (l2_addr_ready)
                    state_next = REFILL_WAIT;
            end
            REFILL_WAIT:
            begin
                if (l2_data_valid)
                    state_next = REFILL_FILL;
            end
            default:
                state_next = REFILL_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= REFILL_IDLE;
        else
            state <= state_next;
    end

    // Block address is taken once and reused for the request and the fill
    always_ff @(posedge clk)
    begin
        if (state == REFILL_IDLE && miss)
            req_addr <= miss_block;
    end

    always_ff @(posedge clk)
    begin
        if (l2_data_ready && l2_data_valid)
            block_q <= l2_data;
    end

    // Outputs decoded from state
    assign l2_addr_valid = (state == REFILL_REQ);
    assign l2_addr       = req_addr;
    assign l2_data_ready = (state == REFILL_WAIT);
    assign fill_valid    = (state == REFILL_FILL);
    assign fill_addr     = req_addr;
    assign fill_block    = block_q;

    // Request held steady until L2 takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        l2_addr_valid && !l2_addr_ready |=> l2_addr_valid && $stable(l2_addr))
        else $error("l2_addr changed before acceptance");

    // Data channel opens only right after an accepted address
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(l2_data_ready) |-> $past(l2_addr_valid && l2_addr_ready))
        else $error("l2_data_ready without an address transfer");

endmodule

`default_nettype wire

/* test/ifetch_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module ifetch_checker import ifetch_pkg::*;
#(
    parameter int                    LINE_COUNT = 8,
    parameter logic [addr_width-1:0] RESET_PC   = '0
)
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  redirect_valid,
    input  wire logic [addr_width-1:0] redirect_pc,
    input  wire logic                  fetch_valid,
    input  wire fetch_out_t            fetch,
    input  wire logic                  l2_addr_valid,
    input  wire l2_req_t               l2_addr,
    input  wire logic                  l2_addr_ready,
    input  wire logic                  l2_data_valid,
    input  wire logic                  l2_data_ready
);

    localparam int index_w = $clog2(LINE_COUNT);

    // Model memory and tag array
    logic [word_width-1:0]       mem [1024];
    logic [block_addr_width-1:0] tag_blk [LINE_COUNT];
    logic [LINE_COUNT-1:0]       tag_v;
    bit                          seen [logic [block_addr_width-1:0]];
    logic [block_addr_width-1:0] allowed [$];

    int err [6];
    int fetched;
    int refills;
    int refetches;
    int rst_cycles;

    logic                        have_last;
    logic                        redirect_seen;
    logic                        outstanding;
    logic                        first_req;
    logic                        after_rst;
    logic                        prev_av;
    logic                        prev_ar;
    logic [addr_width-1:0]       last_pc;
    logic [addr_width-1:0]       redir_target;
    l2_req_t                     prev_addr;
    logic [block_addr_width-1:0] req_blk;

    initial
    begin
        for (int t = 0; t < 6; t++)
            err[t] = 0;
        fetched    = 0;
        refills    = 0;
        refetches  = 0;
        rst_cycles = 0;
    end

    task automatic load_word(input int idx, input logic [word_width-1:0] val);
        mem[idx] = val;
    endtask

    task automatic value_error(input int t, input string name,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        err[t]++;
        $display("ERR %s expected %h actual %h", name, exp_v, act_v);
    endtask

    task automatic plain_error(input int t, input string what);
        err[t]++;
        $display("Check failed: %s", what);
    endtask

    task automatic reset_model();
        rst_cycles++;
        if (rst_cycles > 1 && (fetch_valid !== 1'b0 || l2_addr_valid !== 1'b0))
            plain_error(5, "fetch_valid or l2_addr_valid high during reset");
        have_last     = 1'b0;
        redirect_seen = 1'b0;
        outstanding   = 1'b0;
        first_req     = 1'b1;
        after_rst     = 1'b1;
        prev_av       = 1'b0;
        prev_ar       = 1'b0;
        tag_v         = '0;
        allowed.delete();
    endtask

    task automatic check_fetch();
        logic [addr_width-1:0] exp_pc;
        logic [index_w-1:0]    idx;
        if (!fetch_valid)
            return;
        fetched++;
        if (outstanding)
            plain_error(4, "fetch_valid high while a refill is outstanding");
        // An evicted block has to come back through L2 before it is fetched again
        idx = fetch.pc[6 +: index_w];
        if (!tag_v[idx] || tag_blk[idx] !== fetch.pc[31:6])
            plain_error(3, "instruction delivered from a block that was not refilled");
        if (fetch.instr !== mem[fetch.pc[11:2]])
            value_error(0, "fetch.instr", mem[fetch.pc[11:2]], fetch.instr);
        if (redirect_seen)
            exp_pc = redir_target;
        else if (have_last)
            exp_pc = last_pc + 32'd4;
        else
            exp_pc = RESET_PC;
        if (fetch.pc !== exp_pc)
            value_error(1, "fetch.pc", exp_pc, fetch.pc);
        last_pc       = fetch.pc;
        have_last     = 1'b1;
        redirect_seen = 1'b0;
        allowed.delete();
    endtask

    task automatic check_addr();
        logic [block_addr_width-1:0] blk;
        logic [block_addr_width-1:0] seq_blk;
        logic [index_w-1:0]          idx;
        logic                        ok;
        if (!(l2_addr_valid && l2_addr_ready))
            return;
        blk     = l2_addr.block_addr;
        seq_blk = have_last ? 26'((last_pc + 32'd4) >> 6) : RESET_PC[31:6];
        ok      = (blk == seq_blk);
        foreach (allowed[i])
            if (allowed[i] == blk)
                ok = 1'b1;
        if (first_req && blk !== RESET_PC[31:6])
            value_error(5, "l2_addr.block_addr", 32'(RESET_PC[31:6]), 32'(blk));
        first_req = 1'b0;
        if (!ok)
            value_error(2, "l2_addr.block_addr", 32'(seq_blk), 32'(blk));
        idx = blk[index_w-1:0];
        if (tag_v[idx] && tag_blk[idx] == blk)
            plain_error(2, "L2 request for a block that is resident");
        if (outstanding)
            plain_error(4, "second address transfer before the data transfer");
        if (seen.exists(blk))
            refetches++;
        seen[blk]   = 1'b1;
        refills++;
        outstanding = 1'b1;
        req_blk     = blk;
    endtask

    task automatic check_data();
        if (l2_data_ready && !outstanding)
            plain_error(4, "l2_data_ready high with no address transfer outstanding");
        if (!(l2_data_valid && l2_data_ready && outstanding))
            return;
        tag_v[req_blk[index_w-1:0]]   = 1'b1;
        tag_blk[req_blk[index_w-1:0]] = req_blk;
        outstanding = 1'b0;
    endtask

    task automatic check_stable();
        if (prev_av && !prev_ar && (l2_addr_valid !== 1'b1 || l2_addr !== prev_addr))
            value_error(4, "l2_addr.block_addr", 32'(prev_addr.block_addr),
                        32'(l2_addr.block_addr));
        prev_av   = l2_addr_valid;
        prev_ar   = l2_addr_ready;
        prev_addr = l2_addr;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Sampling on every rising edge
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (!rst_n)
            reset_model();
        else
        begin
            if (after_rst && (fetch_valid !== 1'b0 || l2_addr_valid !== 1'b0))
                plain_error(5, "fetch_valid or l2_addr_valid high right after reset");
            after_rst = 1'b0;
            check_fetch();
            if (redirect_valid)
            begin
                redirect_seen = 1'b1;
                redir_target  = redirect_pc;
                allowed.push_back(redirect_pc[31:6]);
            end
            check_addr();
            check_data();
            check_stable();
        end
    end

    task automatic finish_report(output int failed, output int total);
        string names [6];
        logic  bad;
        names  = '{"instruction data", "PC order", "miss only on absence",
                   "conflict eviction", "L2 handshake", "reset"};
        failed = 0;
        total  = 0;
        for (int t = 0; t < 6; t++)
        begin
            bad = (err[t] > 0) || (t == 0 && fetched == 0) || (t == 3 && refetches == 0);
            if (bad)
                failed++;
            total += err[t];
            if (t == 3)
                $display("test %0d %s: %s (refills %0d, refetched %0d)", t + 1, names[t],
                         bad ? "fail" : "pass", refills, refetches);
            else
                $display("test %0d %s: %s (errors %0d)", t + 1, names[t],
                         bad ? "fail" : "pass", err[t]);
        end
    endtask

endmodule

`default_nettype wire

/* test/ifetch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ifetch_tb import ifetch_pkg::*;
;

    localparam int                    mem_words      = 1024;
    localparam int                    seed           = 26404;
    localparam int                    run_cycles     = 6000;
    localparam int                    stall_limit    = 300;
    localparam int                    word_per_block = 16;
    localparam int                    line_count     = 8;
    localparam logic [addr_width-1:0] reset_pc       = 32'h0;
    localparam int                    block_width    = word_width * word_per_block;

    logic                   clk;
    logic                   rst_n;
    logic                   redirect_valid;
    logic [addr_width-1:0]  redirect_pc;
    logic                   fetch_valid;
    fetch_out_t             fetch;
    logic                   l2_addr_valid;
    l2_req_t                l2_addr;
    logic                   l2_addr_ready;
    logic                   l2_data_valid;
    logic                   l2_data_ready;
    logic [block_width-1:0] l2_data;

    logic [word_width-1:0]  mem [mem_words];
    logic                   addr_taken;
    logic                   data_taken;
    logic                   data_pend;
    int                     data_delay;
    l2_req_t                data_blk;

    always #10 clk = ~clk;

    ifetch_top #(
        .WORD_PER_BLOCK (word_per_block),
        .LINE_COUNT     (line_count),
        .RESET_PC       (reset_pc)
    ) uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .l2_addr_valid  (l2_addr_valid),
        .l2_addr        (l2_addr),
        .l2_addr_ready  (l2_addr_ready),
        .l2_data_valid  (l2_data_valid),
        .l2_data_ready  (l2_data_ready),
        .l2_data        (l2_data)
    );

    ifetch_checker #(
        .LINE_COUNT     (line_count),
        .RESET_PC       (reset_pc)
    ) chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .l2_addr_valid  (l2_addr_valid),
        .l2_addr        (l2_addr),
        .l2_addr_ready  (l2_addr_ready),
        .l2_data_valid  (l2_data_valid),
        .l2_data_ready  (l2_data_ready)
    );

    // Word 0 of the block goes in the top slot
    function automatic logic [block_width-1:0] pack_block(input l2_req_t b);
        logic [block_width-1:0] blk;
        for (int i = 0; i < word_per_block; i++)
            blk[(word_per_block - 1 - i) * word_width +: word_width] =
                mem[{b.block_addr[5:0], 4'(i)}];
        return blk;
    endfunction

    // Half the targets land in blocks 1, 9 and 17, which share line 1
    function automatic logic [addr_width-1:0] pick_target();
        logic [addr_width-1:0] base;
        logic [addr_width-1:0] off;
        off = ($urandom % 32'd16) << 2;
        if ($urandom % 32'd4 < 32'd2)
            base = (($urandom % 32'd3) * 32'd8 + 32'd1) << 6;
        else
            return ($urandom % 32'(mem_words)) << 2;
        return base + off;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // L2 emulator
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            addr_taken <= 1'b0;
            data_taken <= 1'b0;
        end
        else
        begin
            addr_taken <= l2_addr_valid && l2_addr_ready;
            data_taken <= l2_data_valid && l2_data_ready;
            if (l2_addr_valid && l2_addr_ready)
                data_blk <= l2_addr;
        end
    end

    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            l2_addr_ready = 1'b0;
            l2_data_valid = 1'b0;
            data_pend     = 1'b0;
        end
        else
        begin
            l2_addr_ready = 1'($urandom % 32'd2);
            if (data_taken)
            begin
                l2_data_valid = 1'b0;
                data_pend     = 1'b0;
            end
            if (addr_taken)
            begin
                data_pend  = 1'b1;
                data_delay = int'($urandom % 32'd7);
            end
            if (data_pend && !l2_data_valid)
            begin
                if (data_delay == 0)
                begin
                    l2_data_valid = 1'b1;
                    l2_data       = pack_block(data_blk);
                end
                else
                    data_delay--;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////

    initial
    begin
        int   cyc;
        int   stall;
        int   failed;
        int   total;
        logic timed_out;
        clk            = 1'b0;
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        l2_addr_ready  = 1'b0;
        l2_data_valid  = 1'b0;
        l2_data        = '0;
        data_pend      = 1'b0;
        data_delay     = 0;
        void'($urandom(seed));
        for (int i = 0; i < mem_words; i++)
        begin
            mem[i] = $urandom;
            chk.load_word(i, mem[i]);
        end
        repeat (3) @(negedge clk);
        rst_n     = 1'b1;
        cyc       = 0;
        stall     = 0;
        timed_out = 1'b0;
        while (cyc < run_cycles && !timed_out)
        begin
            @(negedge clk);
            cyc++;
            redirect_valid = ($urandom % 32'd32 == 32'd0);
            if (redirect_valid)
                redirect_pc = pick_target();
            stall = fetch_valid ? 0 : stall + 1;
            if (stall > stall_limit)
                timed_out = 1'b1;
        end
        redirect_valid = 1'b0;
        // Let the last refill drain
        cyc = 0;
        while (!timed_out && (l2_addr_valid || l2_data_ready || data_pend))
        begin
            @(negedge clk);
            cyc++;
            if (cyc > stall_limit)
                timed_out = 1'b1;
        end
        if (timed_out)
            $display("Timeout: the fetch unit stopped making progress");
        chk.finish_report(failed, total);
        $display("tests 6, failed %0d, errors %0d", failed, total);
        if (!timed_out && failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
